// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_vsc_response
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sources.f
+incdir+src
src/vsc_axi_pkg.sv
src/vsc_check_pkg.sv
src/vsc_rsp_capture.sv
src/vsc_expected_pattern.sv
src/vsc_compare_stage.sv
src/vsc_error_extract.sv
src/vsc_response_control.sv
src/vsc_response_top.sv
verif/tb_vsc_response.sv

// File: src/vsc_axi_pkg.sv
// ==================================================
// AXI read response channel types
// ==================================================
`include "vsc_config.svh"

package vsc_axi_pkg;

  // AXI response encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } vsc_resp_e;

  // one sample of the read response channel
  // poison comes in on its own user bit
  typedef struct packed {
    logic                   rvalid;
    logic [`VSC_ID_W-1:0]   rid;
    logic [`VSC_DATA_W-1:0] rdata;
    vsc_resp_e              rresp;
    logic                   poison;
  } vsc_rd_resp_t;

endpackage

// File: src/vsc_check_pkg.sv
// ==================================================
// response checker pipeline, report and FSM types
// ==================================================
`include "vsc_config.svh"

package vsc_check_pkg;

  // a response on its way through capture and pattern generation
  typedef struct packed {
    logic [`VSC_ID_W-1:0]   n;
    logic [`VSC_DATA_W-1:0] data;
    logic                   slverr;
    logic                   poison;
  } vsc_beat_t;

  // the same response with N+P and the expanded expected beat
  typedef struct packed {
    vsc_beat_t              beat;
    logic [`VSC_PAT_W-1:0]  npp;
    logic [`VSC_DATA_W-1:0] exp_data;
  } vsc_exp_beat_t;

  // settings of one set of writes
  typedef struct packed {
    logic [`VSC_PAT_W-1:0]      p;
    logic [2:0]                 pattern_size;
    logic [`VSC_DATA_BYTES-1:0] byte_mask;
    logic [`VSC_NAI_W-1:0]      nai;
  } vsc_cfg_t;

  // description of the first mismatch of a set
  typedef struct packed {
    logic [`VSC_ID_W-1:0]  increment;
    logic [`VSC_PAT_W-1:0] expected;
    logic [`VSC_PAT_W-1:0] received;
    logic [`VSC_OFS_W-1:0] byte_offset;
  } vsc_err_report_t;

  typedef enum logic [3:0] {
    IDLE            = 4'd0,
    START           = 4'd1,
    CHECK_COUNT     = 4'd2,
    START_ERROR     = 4'd3,
    COLLECT_ERROR_1 = 4'd4,
    COLLECT_ERROR_2 = 4'd5,
    RECORD_ERROR    = 4'd6,
    PRECOMPLETE     = 4'd7,
    COMPLETE        = 4'd8
  } vsc_state_e;

endpackage

// File: src/vsc_compare_stage.sv
// ==================================================
// byte compare and first-error hold, stages 6 and 7
// ==================================================
`timescale 1ns/1ps
`include "vsc_config.svh"

module vsc_compare_stage
(
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         i_rready,
  input  logic                         i_enable,
  input  logic                         i_valid,
  input  vsc_check_pkg::vsc_exp_beat_t i_exp,
  input  logic [`VSC_DATA_BYTES-1:0]   i_byte_mask,
  output logic                         o_valid,
  output logic                         o_error_found,
  output logic [`VSC_DATA_BYTES-1:0]   o_mismatch_mask,
  output vsc_check_pkg::vsc_exp_beat_t o_err_beat,
  output logic                         o_slverr,
  output logic                         o_poison
);

  localparam int NB = `VSC_DATA_BYTES;

  logic                         s6_valid;
  vsc_check_pkg::vsc_exp_beat_t s6_exp;
  logic [NB-1:0]                s6_mismatch;
  logic [NB-1:0]                byte_diff;

  // one bit per enabled byte that differs from the expected byte
  always_comb
  begin
    for (int i = 0; i < NB; i++)
    begin
      byte_diff[i] = i_byte_mask[i]
                  && (i_exp.beat.data[8*i +: 8] != i_exp.exp_data[8*i +: 8]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n || !i_rready)
    begin
      s6_valid <= 1'b0;
      o_valid  <= 1'b0;
    end
    else
    begin
      s6_valid <= i_valid;
      o_valid  <= s6_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_valid)
    begin
      s6_exp      <= i_exp;
      s6_mismatch <= byte_diff;
    end
  end

  // ==================================================
  // stage 7 keeps the first bad beat until the next enable
  always_ff @(posedge clk)
  begin
    if (!reset_n || i_enable)
    begin
      o_error_found   <= 1'b0;
      o_mismatch_mask <= '0;
      o_slverr        <= 1'b0;
      o_poison        <= 1'b0;
    end
    else if (s6_valid)
    begin
      o_slverr <= o_slverr | s6_exp.beat.slverr;
      o_poison <= o_poison | s6_exp.beat.poison;
      if (!o_error_found)
      begin
        o_error_found   <= |s6_mismatch;
        o_mismatch_mask <= s6_mismatch;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (s6_valid && !o_error_found)
      o_err_beat <= s6_exp;
  end

endmodule

// File: src/vsc_config.svh
// ==================================================
// response checker configuration
// beat size and field widths shared by every block
// ==================================================
`ifndef VSC_CONFIG_SVH
`define VSC_CONFIG_SVH

// bytes per read data beat, which also sizes the byte and compare masks
`define VSC_DATA_BYTES 16

// read data width in bits
`define VSC_DATA_W (`VSC_DATA_BYTES * 8)

// width of a byte offset within one beat
`define VSC_OFS_W ($clog2(`VSC_DATA_BYTES))

// the response ID carries the address increment N
`define VSC_ID_W 8

`define VSC_NAI_W 8

// pattern word width
`define VSC_PAT_W 32

`endif

// File: src/vsc_error_extract.sv
// ==================================================
// first error extraction, byte offset then received pattern
// ==================================================
`timescale 1ns/1ps
`include "vsc_config.svh"

module vsc_error_extract
(
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       i_start,
  input  logic [`VSC_DATA_BYTES-1:0] i_mismatch_mask,
  input  logic [`VSC_DATA_W-1:0]     i_data,
  input  logic [2:0]                 i_pattern_size,
  output logic [`VSC_OFS_W-1:0]      o_byte_offset,
  output logic [`VSC_PAT_W-1:0]      o_pattern
);

  localparam int OFS_W = `VSC_OFS_W;
  localparam int PAT_W = `VSC_PAT_W;

  logic             start_q;
  logic [OFS_W-1:0] first_bad;
  logic [OFS_W-1:0] slot_base;

  // the lowest mismatching byte wins, so scan from the top down
  always_comb
  begin
    first_bad = '0;
    for (int i = `VSC_DATA_BYTES - 1; i >= 0; i--)
    begin
      if (i_mismatch_mask[i])
        first_bad = OFS_W'(i);
    end
  end

  // start of the pattern slot that holds the bad byte
  always_comb
  begin
    case (i_pattern_size)
      3'd4:    slot_base = {o_byte_offset[OFS_W-1:2], 2'b00};
      3'd2:    slot_base = {o_byte_offset[OFS_W-1:1], 1'b0};
      default: slot_base = o_byte_offset;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      start_q <= 1'b0;
    else
      start_q <= i_start;
  end

  always_ff @(posedge clk)
  begin
    if (i_start)
      o_byte_offset <= first_bad;
    if (start_q)
    begin
      case (i_pattern_size)
        3'd4:    o_pattern <= i_data[8*slot_base +: 32];
        3'd2:    o_pattern <= PAT_W'(i_data[8*slot_base +: 16]);
        default: o_pattern <= PAT_W'(i_data[8*slot_base +: 8]);
      endcase
    end
  end

endmodule

// File: src/vsc_expected_pattern.sv
// ==================================================
// expected beat generation, pipeline stages 3 to 5
// forms N+P, sizes it and expands it under the byte mask
// ==================================================
`timescale 1ns/1ps
`include "vsc_config.svh"

module vsc_expected_pattern
(
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         i_rready,
  input  logic                         i_valid,
  input  vsc_check_pkg::vsc_beat_t     i_beat,
  input  vsc_check_pkg::vsc_cfg_t      i_cfg,
  output logic                         o_valid,
  output vsc_check_pkg::vsc_exp_beat_t o_exp
);

  localparam int NB    = `VSC_DATA_BYTES;
  localparam int PAT_W = `VSC_PAT_W;

  logic                     s3_valid;
  vsc_check_pkg::vsc_beat_t s3_beat;
  logic [PAT_W-1:0]         s3_npp;
  logic                     s4_valid;
  vsc_check_pkg::vsc_beat_t s4_beat;
  logic [PAT_W-1:0]         s4_npp;
  logic [PAT_W-1:0]         s4_pattern;
  logic [`VSC_DATA_W-1:0]   expanded;

  // each aligned slot gets a copy of the pattern
  // bytes with a clear mask bit stay zero
  function automatic logic [`VSC_DATA_W-1:0] expand_pattern
  (
    input logic [PAT_W-1:0] pattern,
    input logic [2:0]       size,
    input logic [NB-1:0]    mask
  );
    logic [`VSC_DATA_W-1:0] beat;
    beat = '0;
    for (int i = 0; i < NB; i++)
    begin
      if (mask[i])
      begin
        case (size)
          3'd4:    beat[8*i +: 8] = pattern[8*(i % 4) +: 8];
          3'd2:    beat[8*i +: 8] = pattern[8*(i % 2) +: 8];
          default: beat[8*i +: 8] = pattern[7:0];
        endcase
      end
    end
    return beat;
  endfunction

  always_ff @(posedge clk)
  begin
    if (!reset_n || !i_rready)
    begin
      s3_valid <= 1'b0;
      s4_valid <= 1'b0;
      o_valid  <= 1'b0;
    end
    else
    begin
      s3_valid <= i_valid;
      s4_valid <= s3_valid;
      o_valid  <= s4_valid;
    end
  end

  // ==================================================
  // stage 3 adds the ID to the base pattern of the set
  always_ff @(posedge clk)
  begin
    if (i_valid)
    begin
      s3_beat <= i_beat;
      s3_npp  <= PAT_W'(i_beat.n) + i_cfg.p;
    end
  end

  // stage 4 keeps only the bits of the pattern size
  always_ff @(posedge clk)
  begin
    if (s3_valid)
    begin
      s4_beat <= s3_beat;
      s4_npp  <= s3_npp;
      case (i_cfg.pattern_size)
        3'd4:    s4_pattern <= s3_npp;
        3'd2:    s4_pattern <= PAT_W'(s3_npp[15:0]);
        3'd1:    s4_pattern <= PAT_W'(s3_npp[7:0]);
        default: s4_pattern <= '0;
      endcase
    end
  end

  // stage 5 registers the expanded beat
  assign expanded = expand_pattern(s4_pattern, i_cfg.pattern_size, i_cfg.byte_mask);

  always_ff @(posedge clk)
  begin
    if (s4_valid)
    begin
      o_exp.beat     <= s4_beat;
      o_exp.npp      <= s4_npp;
      o_exp.exp_data <= expanded;
    end
  end

endmodule

// File: src/vsc_response_control.sv
// ==================================================
// response checker control FSM
// counts the responses of a set and sequences error recording
// ==================================================
`timescale 1ns/1ps
`include "vsc_config.svh"

module vsc_response_control
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  i_enable,
  input  logic [`VSC_NAI_W-1:0] i_nai,
  input  logic                  i_rsp_valid,
  input  logic                  i_error_found,
  input  logic                  i_slverr,
  input  logic                  i_poison,
  output logic                  o_busy,
  output logic                  o_rready,
  output logic                  o_start_gather,
  output logic                  o_record_error,
  output logic                  o_slverr,
  output logic                  o_poison
);

  localparam int CNT_W = `VSC_NAI_W + 1;

  vsc_check_pkg::vsc_state_e state;
  vsc_check_pkg::vsc_state_e next_state;
  logic [`VSC_NAI_W-1:0]     nai_q;
  logic [CNT_W-1:0]          rsp_count;
  logic                      count_done;
  logic                      initialize;
  logic                      set_not_busy;

  // a set is complete after NAI+1 responses
  assign count_done = rsp_count >= (CNT_W'(nai_q) + CNT_W'(1));

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      nai_q <= '0;
    else if (i_enable)
      nai_q <= i_nai;
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n || i_enable)
      rsp_count <= '0;
    else if (i_rsp_valid)
      rsp_count <= rsp_count + CNT_W'(1);
  end

  // ==================================================
  // busy, rready and the set flags
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      o_busy   <= 1'b0;
      o_rready <= 1'b0;
    end
    else if (initialize)
    begin
      o_busy   <= 1'b1;
      o_rready <= 1'b1;
    end
    else
    begin
      if (set_not_busy)
        o_busy <= 1'b0;
      if (count_done || set_not_busy)
        o_rready <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n || i_enable)
    begin
      o_slverr <= 1'b0;
      o_poison <= 1'b0;
    end
    else if (state == vsc_check_pkg::PRECOMPLETE)
    begin
      o_slverr <= i_slverr;
      o_poison <= i_poison;
    end
  end

  // ==================================================
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      state <= vsc_check_pkg::IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state     = state;
    initialize     = 1'b0;
    o_start_gather = 1'b0;
    o_record_error = 1'b0;
    set_not_busy   = 1'b0;
    case (state)
      vsc_check_pkg::IDLE:
      begin
        initialize = i_enable;
        if (i_enable)
          next_state = vsc_check_pkg::START;
      end
      vsc_check_pkg::START:
        next_state = vsc_check_pkg::CHECK_COUNT;
      // an error takes priority over the end of the set
      vsc_check_pkg::CHECK_COUNT:
      begin
        if (i_error_found)
          next_state = vsc_check_pkg::START_ERROR;
        else if (count_done)
          next_state = vsc_check_pkg::PRECOMPLETE;
      end
      vsc_check_pkg::START_ERROR:
      begin
        o_start_gather = 1'b1;
        next_state     = vsc_check_pkg::COLLECT_ERROR_1;
      end
      vsc_check_pkg::COLLECT_ERROR_1:
        next_state = vsc_check_pkg::COLLECT_ERROR_2;
      // the extractor outputs settle by the end of this state
      vsc_check_pkg::COLLECT_ERROR_2:
        next_state = vsc_check_pkg::RECORD_ERROR;
      vsc_check_pkg::RECORD_ERROR:
      begin
        o_record_error = 1'b1;
        next_state     = vsc_check_pkg::PRECOMPLETE;
      end
      vsc_check_pkg::PRECOMPLETE:
        next_state = vsc_check_pkg::COMPLETE;
      vsc_check_pkg::COMPLETE:
      begin
        set_not_busy = 1'b1;
        next_state   = vsc_check_pkg::IDLE;
      end
      default:
        next_state = vsc_check_pkg::IDLE;
    endcase
  end

endmodule

// File: src/vsc_response_top.sv
// ==================================================
// read response checker top level
// ==================================================
`timescale 1ns/1ps
`include "vsc_config.svh"

module vsc_response_top
(
  input  logic                           clk,
  input  logic                           reset_n,
  input  vsc_axi_pkg::vsc_rd_resp_t      i_rd_resp,
  input  vsc_check_pkg::vsc_cfg_t        i_cfg,
  input  logic                           i_enable,
  output logic                           o_rready,
  output logic                           o_busy,
  output logic                           o_record_error,
  output logic                           o_error_found,
  output vsc_check_pkg::vsc_err_report_t o_error_report,
  output logic                           o_slverr,
  output logic                           o_poison
);

  vsc_check_pkg::vsc_beat_t     cap_beat;
  logic                         cap_valid;
  vsc_check_pkg::vsc_exp_beat_t exp_beat;
  logic                         exp_valid;
  vsc_check_pkg::vsc_exp_beat_t err_beat;
  logic [`VSC_DATA_BYTES-1:0]   mismatch_mask;
  logic                         rsp_valid;
  logic                         sticky_slverr;
  logic                         sticky_poison;
  logic                         start_gather;
  logic [`VSC_OFS_W-1:0]        err_offset;
  logic [`VSC_PAT_W-1:0]        err_pattern;

  vsc_rsp_capture capture_i
  (
    .clk       ( clk       ),
    .reset_n   ( reset_n   ),
    .i_rd_resp ( i_rd_resp ),
    .i_rready  ( o_rready  ),
    .o_beat    ( cap_beat  ),
    .o_valid   ( cap_valid )
  );

  vsc_expected_pattern expected_i
  (
    .clk      ( clk       ),
    .reset_n  ( reset_n   ),
    .i_rready ( o_rready  ),
    .i_valid  ( cap_valid ),
    .i_beat   ( cap_beat  ),
    .i_cfg    ( i_cfg     ),
    .o_valid  ( exp_valid ),
    .o_exp    ( exp_beat  )
  );

  vsc_compare_stage compare_i
  (
    .clk             ( clk             ),
    .reset_n         ( reset_n         ),
    .i_rready        ( o_rready        ),
    .i_enable        ( i_enable        ),
    .i_valid         ( exp_valid       ),
    .i_exp           ( exp_beat        ),
    .i_byte_mask     ( i_cfg.byte_mask ),
    .o_valid         ( rsp_valid       ),
    .o_error_found   ( o_error_found   ),
    .o_mismatch_mask ( mismatch_mask   ),
    .o_err_beat      ( err_beat        ),
    .o_slverr        ( sticky_slverr   ),
    .o_poison        ( sticky_poison   )
  );

  vsc_error_extract extract_i
  (
    .clk             ( clk                ),
    .reset_n         ( reset_n            ),
    .i_start         ( start_gather       ),
    .i_mismatch_mask ( mismatch_mask      ),
    .i_data          ( err_beat.beat.data ),
    .i_pattern_size  ( i_cfg.pattern_size ),
    .o_byte_offset   ( err_offset         ),
    .o_pattern       ( err_pattern        )
  );

  vsc_response_control control_i
  (
    .clk            ( clk            ),
    .reset_n        ( reset_n        ),
    .i_enable       ( i_enable       ),
    .i_nai          ( i_cfg.nai      ),
    .i_rsp_valid    ( rsp_valid      ),
    .i_error_found  ( o_error_found  ),
    .i_slverr       ( sticky_slverr  ),
    .i_poison       ( sticky_poison  ),
    .o_busy         ( o_busy         ),
    .o_rready       ( o_rready       ),
    .o_start_gather ( start_gather   ),
    .o_record_error ( o_record_error ),
    .o_slverr       ( o_slverr       ),
    .o_poison       ( o_poison       )
  );

  // the report is read while o_record_error is high
  assign o_error_report.increment   = err_beat.beat.n;
  assign o_error_report.expected    = err_beat.npp;
  assign o_error_report.received    = err_pattern;
  assign o_error_report.byte_offset = err_offset;

endmodule

// File: src/vsc_rsp_capture.sv
// ==================================================
// read response capture, pipeline stages 1 and 2
// ==================================================
`timescale 1ns/1ps

module vsc_rsp_capture
(
  input  logic                      clk,
  input  logic                      reset_n,
  input  vsc_axi_pkg::vsc_rd_resp_t i_rd_resp,
  input  logic                      i_rready,
  output vsc_check_pkg::vsc_beat_t  o_beat,
  output logic                      o_valid
);

  logic                      s1_valid;
  vsc_axi_pkg::vsc_rd_resp_t s1_rsp;

  // a beat is only accepted while rready is high
  always_ff @(posedge clk)
  begin
    if (!reset_n || !i_rready)
    begin
      s1_valid <= 1'b0;
      o_valid  <= 1'b0;
    end
    else
    begin
      s1_valid <= i_rd_resp.rvalid;
      o_valid  <= s1_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_rready && i_rd_resp.rvalid)
      s1_rsp <= i_rd_resp;
  end

  // stage 2 turns SLVERR and poison into per-beat flags
  always_ff @(posedge clk)
  begin
    if (s1_valid)
    begin
      o_beat.n      <= s1_rsp.rid;
      o_beat.data   <= s1_rsp.rdata;
      o_beat.slverr <= (s1_rsp.rresp == vsc_axi_pkg::RESP_SLVERR);
      o_beat.poison <= s1_rsp.poison;
    end
  end

endmodule

// File: verif/tb_vsc_response.sv
// ==================================================
// testbench for the read response checker
// replays read beats from a trace and checks every set
// ==================================================
`timescale 1ns/1ps
`include "vsc_config.svh"

module tb_vsc_response;

  localparam int    WAIT_LIMIT = 64;
  localparam string TRACE_PATH = "verif/vsc_trace.txt";

  logic                           clk = 1'b0;
  logic                           reset_n;
  vsc_axi_pkg::vsc_rd_resp_t      rd_resp;
  vsc_check_pkg::vsc_cfg_t        cfg;
  logic                           enable;
  logic                           rready;
  logic                           busy;
  logic                           record_error;
  logic                           error_found;
  vsc_check_pkg::vsc_err_report_t error_report;
  logic                           slverr;
  logic                           poison;

  // the set being replayed and what the DUT reported for it
  vsc_axi_pkg::vsc_rd_resp_t      beats[$];
  vsc_check_pkg::vsc_cfg_t        set_cfg;
  vsc_check_pkg::vsc_err_report_t seen_report;
  int                             record_pulses;

  always #10 clk = ~clk;

  vsc_response_top dut_i
  (
    .clk            ( clk          ),
    .reset_n        ( reset_n      ),
    .i_rd_resp      ( rd_resp      ),
    .i_cfg          ( cfg          ),
    .i_enable       ( enable       ),
    .o_rready       ( rready       ),
    .o_busy         ( busy         ),
    .o_record_error ( record_error ),
    .o_error_found  ( error_found  ),
    .o_error_report ( error_report ),
    .o_slverr       ( slverr       ),
    .o_poison       ( poison       )
  );

  // ==================================================
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_report
  (
    input vsc_check_pkg::vsc_err_report_t got,
    input vsc_check_pkg::vsc_err_report_t exp
  );
    if (got !== exp)
    begin
      $display("FAIL %0t o_error_report got %h expected %h", $time, got, exp);
      $display("TEST FAILED");
      $fatal(1, "o_error_report mismatch");
    end
  endtask

  // ==================================================
  task automatic wait_rready();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (rready !== 1'b1 && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (rready !== 1'b1)
      abort_run("timeout while waiting for o_rready to rise");
  endtask

  // record pulses are counted and the report taken while the set drains
  task automatic wait_idle();
    int cycles;
    cycles        = 0;
    record_pulses = 0;
    do
    begin
      @(negedge clk);
      cycles++;
      if (record_error === 1'b1)
      begin
        record_pulses++;
        seen_report = error_report;
      end
    end
    while (busy !== 1'b0 && cycles < WAIT_LIMIT);
    if (busy !== 1'b0)
      abort_run("timeout while waiting for o_busy to fall");
  endtask

  task automatic run_set();
    @(posedge clk);
    cfg    <= set_cfg;
    enable <= 1'b1;
    @(posedge clk);
    enable <= 1'b0;
    // the enable edge clears whatever the previous set left behind
    @(negedge clk);
    check_flag("o_busy", busy, 1'b1);
    check_flag("o_error_found", error_found, 1'b0);
    check_flag("o_slverr", slverr, 1'b0);
    check_flag("o_poison", poison, 1'b0);
    foreach (beats[i])
    begin
      wait_rready();
      @(posedge clk);
      rd_resp <= beats[i];
    end
    @(posedge clk);
    rd_resp <= '0;
    wait_idle();
  endtask

  task automatic verify_set_results
  (
    input logic                           exp_err,
    input int                             exp_pulses,
    input logic                           exp_slverr,
    input logic                           exp_poison,
    input vsc_check_pkg::vsc_err_report_t exp_report
  );
    check_flag("o_rready", rready, 1'b0);
    check_flag("o_error_found", error_found, exp_err);
    check_count("o_record_error pulses", record_pulses, exp_pulses);
    check_flag("o_slverr", slverr, exp_slverr);
    check_flag("o_poison", poison, exp_poison);
    if (exp_pulses > 0)
      check_report(seen_report, exp_report);
  endtask

  // ==================================================
  initial
  begin
    int                             fd;
    int                             n_read;
    int                             n_sets;
    string                          line;
    logic [`VSC_PAT_W-1:0]          p;
    logic [2:0]                     size;
    logic [`VSC_DATA_BYTES-1:0]     mask;
    logic [`VSC_NAI_W-1:0]          nai;
    logic [`VSC_ID_W-1:0]           rid;
    logic [1:0]                     resp;
    logic                           poison_bit;
    logic [`VSC_DATA_W-1:0]         data;
    vsc_axi_pkg::vsc_rd_resp_t      beat;
    logic                           exp_err;
    int                             exp_pulses;
    logic                           exp_slverr;
    logic                           exp_poison;
    logic [`VSC_ID_W-1:0]           inc;
    logic [`VSC_PAT_W-1:0]          exp_pat;
    logic [`VSC_PAT_W-1:0]          rcv_pat;
    logic [`VSC_OFS_W-1:0]          ofs;
    vsc_check_pkg::vsc_err_report_t exp_report;

    rd_resp <= '0;
    cfg     <= '0;
    enable  <= 1'b0;
    reset_n <= 1'b0;
    n_sets  = 0;
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_flag("o_busy", busy, 1'b0);
    check_flag("o_rready", rready, 1'b0);
    check_flag("o_record_error", record_error, 1'b0);
    check_flag("o_error_found", error_found, 1'b0);

    fd = $fopen(TRACE_PATH, "r");
    if (fd == 0)
      abort_run("could not open the trace file");
    while (!$feof(fd))
    begin
      line   = "";
      n_read = $fgets(line, fd);
      if (n_read == 0 || line.len() < 2 || line.getc(0) == "#")
        continue;
      case (line.getc(0))
        "C":
        begin
          n_read = $sscanf(line, "C %h %h %h %h", p, size, mask, nai);
          if (n_read != 4)
            abort_run("malformed config line in the trace");
          set_cfg.p            = p;
          set_cfg.pattern_size = size;
          set_cfg.byte_mask    = mask;
          set_cfg.nai          = nai;
          beats.delete();
        end
        "B":
        begin
          n_read = $sscanf(line, "B %h %h %h %h", rid, resp, poison_bit, data);
          if (n_read != 4)
            abort_run("malformed beat line in the trace");
          beat.rvalid = 1'b1;
          beat.rid    = rid;
          beat.rdata  = data;
          beat.rresp  = vsc_axi_pkg::vsc_resp_e'(resp);
          beat.poison = poison_bit;
          beats.push_back(beat);
        end
        "E":
        begin
          n_read = $sscanf(line, "E %h %d %h %h %h %h %h %h", exp_err, exp_pulses,
                           exp_slverr, exp_poison, inc, exp_pat, rcv_pat, ofs);
          if (n_read != 8)
            abort_run("malformed result line in the trace");
          if (beats.size() == 0)
            abort_run("a set in the trace has no beats");
          exp_report.increment   = inc;
          exp_report.expected    = exp_pat;
          exp_report.received    = rcv_pat;
          exp_report.byte_offset = ofs;
          run_set();
          verify_set_results(exp_err, exp_pulses, exp_slverr, exp_poison, exp_report);
          n_sets++;
          $display("set %0d checked with %0d beats", n_sets, beats.size());
        end
        default:
          abort_run("unknown line in the trace");
      endcase
    end
    $fclose(fd);

    if (n_sets == 0)
      abort_run("the trace holds no sets");
    else
    begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// File: verif/vsc_trace.txt
# C <p> <pattern size> <byte mask> <nai>, hex, starts a set
# B <rid> <rresp> <poison> <rdata>, hex, one read beat per line
# E <error found> <record pulses> <slverr> <poison> <increment> <expected> <received> <offset>
C 10000000 4 ffff 03
B 00 0 0 10000000100000001000000010000000
B 01 0 0 10000001100000011000000110000001
B 02 0 0 10000002100000021000000210000002
B 03 0 0 10000003100000031000000310000003
E 0 0 0 0 00 00000000 00000000 0
C 0000a5c0 2 0ff0 02
B 10 0 0 a5d0a5d0a5d0a5d0a5d0a5d0a5d0a5d0
B 11 0 0 a5d1a5d1a5d177d15ad1a5d100d1a5d1
B 12 0 0 a5d2a5d2a5d2a5d2a5d2a5d2a5d2a5d2
E 1 1 0 0 11 0000a5d1 00005ad1 7
C 00000030 1 00ff 01
B 05 0 0 35353535353535353535353535353535
B 06 0 0 0123456789abcdef3636363636363636
E 0 0 0 0 00 00000000 00000000 0
C 12340000 4 ffff 03
B 20 0 0 12340020123400201234002012340020
B 21 0 0 1234ee21123400211234002112340021
B 22 0 0 12340022123400221234002212000022
B 23 0 0 12340023123400231234002312340023
E 1 1 0 0 21 12340021 1234ee21 d
C 50000000 4 ffff 02
B 30 2 0 50000030500000305000003050000030
B 31 0 1 50000031500000315000003150000031
B 32 0 0 50000032500000325000003250000032
E 0 0 1 1 00 00000000 00000000 0
C 00007000 2 ffff 00
B 01 0 0 70017001700170017001700170017001
E 0 0 0 0 00 00000000 00000000 0
